/* logic/traffic_config.svh */
`ifndef TRAFFIC_CONFIG_SVH
`define TRAFFIC_CONFIG_SVH

// Phase timer count width
`define TC_TIMER_WIDTH 6

// Count at which each timed phase ends
// A phase lasts its value plus one cycle since the timer starts at 0
`define TC_STARTUP_CYCLES 5
`define TC_GREEN_CYCLES 30
`define TC_YELLOW_CYCLES 5
`define TC_WALK_CYCLES 10

`endif

/* logic/traffic_pkg.sv */
package traffic_pkg;

    // Lamp code shown on one signal head
    typedef enum logic [1:0] {
        RED    = 2'b00,
        GREEN  = 2'b01,
        YELLOW = 2'b10,
        OFF    = 2'b11
    } light_t;

    // Phases of the signal plan
    typedef enum logic [2:0] {
        STARTUP_FLASH,
        NS_GREEN,
        NS_YELLOW,
        EW_GREEN,
        EW_YELLOW,
        PED_WALK,
        EMERGENCY
    } phase_t;

    // Conditioned requests from the field inputs
    typedef struct packed {
        logic emergency;
        logic ped_pending;
    } requests_t;

    // Registered outputs of the crossing
    typedef struct packed {
        light_t ns;
        light_t ew;
        logic   walk;
        logic   emergency_active;
    } lamp_state_t;

endpackage

/* logic/phase_timer.sv */
`timescale 1ns/10ps

`include "traffic_config.svh"

module phase_timer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    output logic [`TC_TIMER_WIDTH-1:0] count
);

    // Counts up from the start pulse and holds at all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (count != '1) begin
            // Saturate so a long emergency hold never wraps
            count <= count + 1'b1;
        end
    end

endmodule

/* logic/request_conditioner.sv */
`timescale 1ns/10ps

module request_conditioner (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   emergency,
    input  logic                   pedestrian_req,
    input  logic                   ped_served,
    output traffic_pkg::requests_t requests
);
    import traffic_pkg::*;

    logic [1:0] emergency_sync;
    logic [1:0] ped_sync;
    logic       ped_latch;

    // Two flop synchronisers for the asynchronous field inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            emergency_sync <= 2'b00;
            ped_sync       <= 2'b00;
        end else begin
            emergency_sync <= {emergency_sync[0], emergency};
            ped_sync       <= {ped_sync[0], pedestrian_req};
        end
    end

    // Holds a short press until the walk phase serves it
    // A new press wins over the served clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ped_latch <= 1'b0;
        end else if (ped_sync[1]) begin
            ped_latch <= 1'b1;
        end else if (ped_served) begin
            ped_latch <= 1'b0;
        end
    end

    assign requests.emergency   = emergency_sync[1];
    assign requests.ped_pending = ped_sync[1] | ped_latch;

endmodule

/* logic/phase_sequencer.sv */
`timescale 1ns/10ps

`include "traffic_config.svh"

module phase_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  traffic_pkg::requests_t requests,
    output traffic_pkg::phase_t    phase,
    output logic                   ped_served
);
    import traffic_pkg::*;

    // Terminal counts at timer width
    localparam logic [`TC_TIMER_WIDTH-1:0] STARTUP_END =
        `TC_TIMER_WIDTH'(`TC_STARTUP_CYCLES);
    localparam logic [`TC_TIMER_WIDTH-1:0] GREEN_END =
        `TC_TIMER_WIDTH'(`TC_GREEN_CYCLES);
    localparam logic [`TC_TIMER_WIDTH-1:0] YELLOW_END =
        `TC_TIMER_WIDTH'(`TC_YELLOW_CYCLES);
    localparam logic [`TC_TIMER_WIDTH-1:0] WALK_END =
        `TC_TIMER_WIDTH'(`TC_WALK_CYCLES);

    phase_t                      next_phase;
    phase_t                      return_phase;
    phase_t                      next_return;
    logic                        preempt;
    logic                        timer_start;
    logic [`TC_TIMER_WIDTH-1:0]  timer_count;

    phase_timer phase_timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .count (timer_count)
    );

    // Emergency overrides every plan phase except the flash phases
    assign preempt = requests.emergency
                   && (phase != STARTUP_FLASH)
                   && (phase != EMERGENCY);

    always_comb begin
        next_phase  = phase;
        next_return = return_phase;

        if (preempt) begin
            next_phase = EMERGENCY;
        end else begin
            case (phase)
                STARTUP_FLASH: begin
                    if (timer_count >= STARTUP_END) begin
                        next_phase = NS_GREEN;
                    end
                end
                NS_GREEN: begin
                    if (timer_count >= GREEN_END) begin
                        next_phase = NS_YELLOW;
                    end
                end
                NS_YELLOW: begin
                    if (timer_count >= YELLOW_END) begin
                        if (requests.ped_pending) begin
                            // Walk first, then resume with the crossing green
                            next_phase  = PED_WALK;
                            next_return = EW_GREEN;
                        end else begin
                            next_phase = EW_GREEN;
                        end
                    end
                end
                EW_GREEN: begin
                    if (timer_count >= GREEN_END) begin
                        next_phase = EW_YELLOW;
                    end
                end
                EW_YELLOW: begin
                    if (timer_count >= YELLOW_END) begin
                        if (requests.ped_pending) begin
                            next_phase  = PED_WALK;
                            next_return = NS_GREEN;
                        end else begin
                            next_phase = NS_GREEN;
                        end
                    end
                end
                PED_WALK: begin
                    if (timer_count >= WALK_END) begin
                        next_phase = return_phase;
                    end
                end
                EMERGENCY: begin
                    // Restart the plan with a full flash once released
                    if (!requests.emergency) begin
                        next_phase = STARTUP_FLASH;
                    end
                end
                default: begin
                    next_phase = STARTUP_FLASH;
                end
            endcase
        end
    end

    // Timer restarts on every phase change so it reads 0 in the new phase
    assign timer_start = (next_phase != phase);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= STARTUP_FLASH;
            return_phase <= NS_GREEN;
            ped_served   <= 1'b0;
        end else begin
            phase        <= next_phase;
            return_phase <= next_return;
            // High for the first cycle of the walk
            ped_served   <= (next_phase == PED_WALK) && (phase != PED_WALK);
        end
    end

endmodule

/* logic/lamp_driver.sv */
`timescale 1ns/10ps

module lamp_driver (
    input  logic                     clk,
    input  logic                     rst_n,
    input  traffic_pkg::phase_t      phase,
    output traffic_pkg::lamp_state_t lamps
);
    import traffic_pkg::*;

    phase_t      phase_q;
    logic        toggle_q;
    logic        flash_red;
    light_t      flash_code;
    lamp_state_t lamps_next;

    // Flash restarts at OFF whenever the phase changes
    assign flash_red  = (phase != phase_q) ? 1'b0 : toggle_q;
    assign flash_code = flash_red ? RED : OFF;

    always_comb begin
        lamps_next.ns               = RED;
        lamps_next.ew               = RED;
        lamps_next.walk             = 1'b0;
        lamps_next.emergency_active = 1'b0;
        case (phase)
            STARTUP_FLASH: begin
                lamps_next.ns = flash_code;
                lamps_next.ew = flash_code;
            end
            NS_GREEN:  lamps_next.ns = GREEN;
            NS_YELLOW: lamps_next.ns = YELLOW;
            EW_GREEN:  lamps_next.ew = GREEN;
            EW_YELLOW: lamps_next.ew = YELLOW;
            PED_WALK:  lamps_next.walk = 1'b1;
            EMERGENCY: begin
                lamps_next.ns               = flash_code;
                lamps_next.ew               = flash_code;
                lamps_next.emergency_active = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q  <= STARTUP_FLASH;
            toggle_q <= 1'b0;
            lamps    <= '{ns: RED, ew: RED, walk: 1'b0, emergency_active: 1'b0};
        end else begin
            phase_q  <= phase;
            toggle_q <= ~flash_red;
            lamps    <= lamps_next;
        end
    end

endmodule

/* logic/traffic_intersection.sv */
`timescale 1ns/10ps

module traffic_intersection (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     emergency,
    input  logic                     pedestrian_req,
    output traffic_pkg::lamp_state_t lamps
);
    import traffic_pkg::*;

    requests_t requests;
    phase_t    phase;
    logic      ped_served;

    // Decode stage
    request_conditioner request_conditioner_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .emergency      (emergency),
        .pedestrian_req (pedestrian_req),
        .ped_served     (ped_served),
        .requests       (requests)
    );

    // Execute stage that returns the served pulse to the pedestrian latch
    phase_sequencer phase_sequencer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .requests   (requests),
        .phase      (phase),
        .ped_served (ped_served)
    );

    // Result stage
    lamp_driver lamp_driver_i (
        .clk   (clk),
        .rst_n (rst_n),
        .phase (phase),
        .lamps (lamps)
    );

endmodule

/* dv/tb_traffic_intersection.sv */
`timescale 1ns/10ps

`include "traffic_config.svh"

module tb_traffic_intersection;
    import traffic_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int STARTUP_LEN  = 8;
    localparam int PLAN_LEN     = 160;
    localparam int PED_LEN      = 500;
    localparam int EMERG_LEN    = 500;
    localparam int MIXED_LEN    = 1200;
    localparam int TOTAL_CYCLES = RESET_CYCLES + STARTUP_LEN + PLAN_LEN + PED_LEN
                                + EMERG_LEN + MIXED_LEN;
    localparam int TIMER_MAX    = (1 << `TC_TIMER_WIDTH) - 1;

    logic        clk;
    logic        rst_n;
    logic        emergency;
    logic        pedestrian_req;
    lamp_state_t lamps;

    logic [31:0] lfsr;
    int          check_count;
    int          error_count;
    int          ped_gap;
    int          emg_gap;
    int          emg_left;

    // Cycle model state
    logic [1:0]  m_esync;
    logic [1:0]  m_psync;
    logic        m_latch;
    logic        m_served;
    phase_t      m_phase;
    phase_t      m_return;
    int          m_count;
    phase_t      m_lamp_phase;
    logic        m_flash;
    lamp_state_t m_lamps;
    phase_t      last_checked;

    traffic_intersection traffic_intersection_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .emergency      (emergency),
        .pedestrian_req (pedestrian_req),
        .lamps          (lamps)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // Count at which a timed phase ends
    function automatic int phase_length(input phase_t ph);
        case (ph)
            STARTUP_FLASH: return `TC_STARTUP_CYCLES;
            NS_GREEN, EW_GREEN: return `TC_GREEN_CYCLES;
            NS_YELLOW, EW_YELLOW: return `TC_YELLOW_CYCLES;
            PED_WALK: return `TC_WALK_CYCLES;
            default: return TIMER_MAX + 1;
        endcase
    endfunction

    function automatic lamp_state_t phase_lamps(input phase_t ph, input logic flash_red);
        lamp_state_t l;
        light_t      flash;
        flash = flash_red ? RED : OFF;
        l = '{ns: RED, ew: RED, walk: 1'b0, emergency_active: 1'b0};
        case (ph)
            STARTUP_FLASH: begin
                l.ns = flash;
                l.ew = flash;
            end
            NS_GREEN:  l.ns = GREEN;
            NS_YELLOW: l.ns = YELLOW;
            EW_GREEN:  l.ew = GREEN;
            EW_YELLOW: l.ew = YELLOW;
            PED_WALK:  l.walk = 1'b1;
            EMERGENCY: begin
                l.ns               = flash;
                l.ew               = flash;
                l.emergency_active = 1'b1;
            end
            default: ;
        endcase
        return l;
    endfunction

    // Phase as seen on the lamp outputs
    function automatic phase_t decode_phase(input lamp_state_t l);
        if (l.emergency_active) return EMERGENCY;
        if (l.walk) return PED_WALK;
        if (l.ns == GREEN) return NS_GREEN;
        if (l.ns == YELLOW) return NS_YELLOW;
        if (l.ew == GREEN) return EW_GREEN;
        if (l.ew == YELLOW) return EW_YELLOW;
        return STARTUP_FLASH;
    endfunction

    function automatic string lamps_text(input lamp_state_t l);
        return $sformatf("ns=%s ew=%s walk=%b emergency=%b",
                         l.ns.name(), l.ew.name(), l.walk, l.emergency_active);
    endfunction

    task automatic check_lamps(input string test, input lamp_state_t exp,
                               input lamp_state_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: lamps expected %s actual %s at %0t",
                     test, lamps_text(exp), lamps_text(act), $time);
        end
    endtask

    task automatic check_phase(input string test, input phase_t exp, input phase_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: phase expected %s actual %s at %0t",
                     test, exp.name(), act.name(), $time);
        end
    endtask

    task automatic reset_model();
        m_esync      = 2'b00;
        m_psync      = 2'b00;
        m_latch      = 1'b0;
        m_served     = 1'b0;
        m_phase      = STARTUP_FLASH;
        m_return     = NS_GREEN;
        m_count      = 0;
        m_lamp_phase = STARTUP_FLASH;
        m_flash      = 1'b0;
        m_lamps      = '{ns: RED, ew: RED, walk: 1'b0, emergency_active: 1'b0};
        last_checked = STARTUP_FLASH;
    endtask

    // One rising edge of the crossing with every update taken from the old state
    task automatic step_model();
        logic   req_emg;
        logic   req_ped;
        logic   flash_red;
        phase_t nxt;
        phase_t nxt_ret;
        phase_t opposite;
        req_emg  = m_esync[1];
        req_ped  = m_psync[1] | m_latch;
        nxt      = m_phase;
        nxt_ret  = m_return;
        opposite = (m_phase == NS_YELLOW) ? EW_GREEN : NS_GREEN;
        if (req_emg && m_phase != STARTUP_FLASH && m_phase != EMERGENCY) begin
            nxt = EMERGENCY;
        end else if (m_phase == EMERGENCY) begin
            if (!req_emg) begin
                nxt = STARTUP_FLASH;
            end
        end else if (m_count >= phase_length(m_phase)) begin
            case (m_phase)
                STARTUP_FLASH: nxt = NS_GREEN;
                NS_GREEN:      nxt = NS_YELLOW;
                EW_GREEN:      nxt = EW_YELLOW;
                PED_WALK:      nxt = m_return;
                NS_YELLOW, EW_YELLOW: begin
                    if (req_ped) begin
                        nxt     = PED_WALK;
                        nxt_ret = opposite;
                    end else begin
                        nxt = opposite;
                    end
                end
                default: nxt = STARTUP_FLASH;
            endcase
        end

        // Lamp stage registers the old phase
        flash_red    = (m_phase == m_lamp_phase) ? m_flash : 1'b0;
        m_lamps      = phase_lamps(m_phase, flash_red);
        m_flash      = !flash_red;
        m_lamp_phase = m_phase;

        if (m_psync[1]) begin
            m_latch = 1'b1;
        end else if (m_served) begin
            m_latch = 1'b0;
        end
        m_served = (nxt == PED_WALK) && (m_phase != PED_WALK);
        m_count  = (nxt != m_phase) ? 0 : ((m_count < TIMER_MAX) ? m_count + 1 : TIMER_MAX);
        m_phase  = nxt;
        m_return = nxt_ret;
        m_esync  = {m_esync[0], emergency};
        m_psync  = {m_psync[0], pedestrian_req};
    endtask

    task automatic drive_inputs(input bit ped_en, input bit emg_en);
        int r;
        pedestrian_req = 1'b0;
        if (ped_en) begin
            if (ped_gap == 0) begin
                pedestrian_req = 1'b1;
                take_bits(7, r);
                ped_gap = 15 + r;
            end else begin
                ped_gap--;
            end
        end
        if (!emg_en) begin
            emergency = 1'b0;
            emg_left  = 0;
        end else if (emg_left > 0) begin
            emergency = 1'b1;
            emg_left--;
        end else if (emg_gap > 0) begin
            emergency = 1'b0;
            emg_gap--;
        end else begin
            // Window of 3 to 40 cycles, then a long quiet gap
            emergency = 1'b0;
            take_bits(6, r);
            emg_left = 3 + (r % 38);
            take_bits(7, r);
            emg_gap = 120 + r;
        end
    endtask

    task automatic compare_outputs(input string test);
        check_lamps(test, m_lamps, lamps);
        if (m_lamp_phase != last_checked) begin
            check_phase(test, m_lamp_phase, decode_phase(lamps));
            last_checked = m_lamp_phase;
        end
    endtask

    task automatic run_cycles(input string test, input int cycles,
                              input bit ped_en, input bit emg_en);
        repeat (cycles) begin
            @(posedge clk);
            step_model();
            #2;
            drive_inputs(ped_en, emg_en);
            @(negedge clk);
            compare_outputs(test);
        end
    endtask

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Run timed out before all tests finished");
        $display("checks %0d errors %0d", check_count, error_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        emergency      = 1'b0;
        pedestrian_req = 1'b0;
        lfsr           = 32'h53b6d69b;
        check_count    = 0;
        error_count    = 0;
        ped_gap        = 10;
        emg_gap        = 20;
        emg_left       = 0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        run_cycles("startup", STARTUP_LEN, 1'b0, 1'b0);
        run_cycles("plan", PLAN_LEN, 1'b0, 1'b0);
        run_cycles("pedestrian", PED_LEN, 1'b1, 1'b0);
        run_cycles("emergency", EMERG_LEN, 1'b0, 1'b1);
        run_cycles("mixed", MIXED_LEN, 1'b1, 1'b1);

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/traffic_pkg.sv
logic/phase_timer.sv
logic/request_conditioner.sv
logic/phase_sequencer.sv
logic/lamp_driver.sv
logic/traffic_intersection.sv
dv/tb_traffic_intersection.sv

/* Bender.yml */
package:
  name: traffic_intersection

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/traffic_pkg.sv
      - logic/phase_timer.sv
      - logic/request_conditioner.sv
      - logic/phase_sequencer.sv
      - logic/lamp_driver.sv
      - logic/traffic_intersection.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_traffic_intersection.sv
